// ==== files.f ====
+incdir+design
design/qa_mem_pkg.sv
design/qa_status_pkg.sv
design/qa_csr_capture.sv
design/qa_status_manager.sv
design/qa_mem_port.sv
design/qa_status_top.sv
testbench/qa_status_tb.sv

// ==== Makefile ====
# Verilator build and run of the host-status agent testbench

SIM     ?= verilator
TOP     ?= qa_status_tb
LOG     ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing

FLIST := files.f
SRCS  := $(filter-out +%,$(shell cat $(FLIST))) design/qa_macros.svh
BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx 'Simulation finished: PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/qa_status_tb.sv ====
`default_nettype none

`include "qa_macros.svh"

module qa_status_tb;

    import qa_mem_pkg::*;
    import qa_status_pkg::*;

    // DSM base used by every test
    localparam logic [31:0] BASE = 32'h0000_4000;

    // The watchdog limit is built from these cycle budgets
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_BUDGET = 100;
    localparam int QUIET_CYCLES = 40;
    localparam int NUM_TESTS = 6;
    localparam int TEST_BUDGET = WAIT_BUDGET + QUIET_CYCLES + 30;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_BUDGET + 200;

    logic clk;
    logic resetb;
    logic csr_wr_valid;
    csr_op_t csr_wr_op;
    logic [31:0] csr_wr_data;
    logic mem_req;
    mem_req_t mem_req_data;
    logic mem_ack;
    mem_rsp_t mem_rsp;
    fifo_local_ptrs_t fifo_local;
    fifo_host_ptrs_t fifo_host;
    dbg_words_t dbg;
    logic [7:0] sreg_req_addr;
    logic sreg_req_rdy;
    logic [31:0] sreg_rsp;
    logic sreg_rsp_enable;

    // Host memory model state
    logic [`QA_LINE_BITS-1:0] poll_line;
    logic [31:0] wr_addr_q[$];
    logic [`QA_LINE_BITS-1:0] wr_data_q[$];
    logic [31:0] rd_addr_q[$];
    logic [31:0] lcg_state;

    int errors;
    int checks;

    qa_status_top i_dut
    (
        .clk                (clk),
        .resetb             (resetb),
        .csr_wr_valid       (csr_wr_valid),
        .csr_wr_op          (csr_wr_op),
        .csr_wr_data        (csr_wr_data),
        .mem_req            (mem_req),
        .mem_req_data       (mem_req_data),
        .mem_ack            (mem_ack),
        .mem_rsp            (mem_rsp),
        .fifo_local         (fifo_local),
        .fifo_host          (fifo_host),
        .dbg                (dbg),
        .sreg_req_addr      (sreg_req_addr),
        .sreg_req_rdy       (sreg_req_rdy),
        .sreg_rsp           (sreg_rsp),
        .sreg_rsp_enable    (sreg_rsp_enable)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==========================================================
    // Helpers
    // ==========================================================

    // Classic 32-bit LCG whose upper bits are the better random ones
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (expected !== actual)
        begin
            $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic csr_write(input csr_op_t op, input logic [31:0] data);
        @(negedge clk);
        csr_wr_valid = 1'b1;
        csr_wr_op = op;
        csr_wr_data = data;
        @(negedge clk);
        csr_wr_valid = 1'b0;
    endtask

    // Pops the oldest DSM write seen by the host model
    task automatic take_write(input string name, output logic [31:0] addr,
                              output logic [127:0] data);
        int n;
        n = 0;
        addr = '0;
        data = '0;
        while ((wr_addr_q.size() == 0) && (n < WAIT_BUDGET))
        begin
            @(negedge clk);
            n++;
        end
        if (wr_addr_q.size() == 0)
        begin
            $display("Error in %s: no DSM write arrived within %0d cycles", name, WAIT_BUDGET);
            errors++;
        end
        else
        begin
            addr = wr_addr_q.pop_front();
            data = wr_data_q.pop_front();
        end
        // The grant lands a cycle after ack and the writer settles one later
        repeat (4) @(negedge clk);
    endtask

    // ==========================================================
    // Host memory model
    // ==========================================================

    // Answers each four-phase request after a random 1 to 4 cycle delay
    initial
    begin
        int unsigned delay;
        mem_ack = 1'b0;
        mem_rsp = '0;
        lcg_state = 32'd60417;
        forever
        begin
            @(negedge clk);
            if (mem_req && !mem_ack)
            begin
                delay = 32'd1 + (lcg_next() % 32'd4);
                repeat (delay) @(negedge clk);
                if (mem_req_data.op == MEM_WR_LINE)
                begin
                    wr_addr_q.push_back(mem_req_data.addr);
                    wr_data_q.push_back(mem_req_data.data);
                end
                else
                begin
                    rd_addr_q.push_back(mem_req_data.addr);
                    mem_rsp.data = poll_line;
                end
                mem_ack = 1'b1;
                while (mem_req)
                    @(negedge clk);
                mem_ack = 1'b0;
            end
        end
    end

    // ==========================================================
    // Tests
    // ==========================================================

    // Expected ID line with depths of 2**6 - 1 on both rings
    function automatic logic [127:0] id_line();
        return {32'd63, 32'd63, `QA_AFU_ID1, `QA_AFU_ID0};
    endfunction

    task automatic test_id_line();
        logic [31:0] addr;
        logic [127:0] data;
        // Without a DSM base the agent stays silent and knows no host pointers
        check_value("id_line", 128'(1'b0), 128'(mem_req));
        check_value("id_line", 128'(1'b0), 128'(sreg_req_rdy));
        check_value("id_line", 128'd0, 128'(fifo_host));
        csr_write(CSR_DSM_BASE, BASE);
        take_write("id_line", addr, data);
        check_value("id_line", 128'(BASE), 128'(addr));
        check_value("id_line", id_line(), data);
    endtask

    task automatic test_poll();
        int n;
        logic [31:0] addr;
        n = 0;
        poll_line = {64'd0, 32'd40, 32'd17};
        while (!((fifo_host.newest_read_idx == 6'd17) &&
                 (fifo_host.oldest_write_idx == 6'd40)) && (n < WAIT_BUDGET))
        begin
            @(negedge clk);
            n++;
        end
        check_value("poll", 128'(6'd17), 128'(fifo_host.newest_read_idx));
        check_value("poll", 128'(6'd40), 128'(fifo_host.oldest_write_idx));
        if (rd_addr_q.size() == 0)
        begin
            $display("Error in poll: the agent never read the poll line");
            errors++;
        end
        while (rd_addr_q.size() != 0)
        begin
            addr = rd_addr_q.pop_front();
            check_value("poll", 128'(BASE + 32'd4), 128'(addr));
        end
    endtask

    task automatic test_sreg();
        logic [31:0] addr;
        logic [127:0] data;
        csr_write(CSR_SREG_REQ, 32'd5);
        repeat (2) @(negedge clk);
        check_value("sreg", 128'(8'd5), 128'(sreg_req_addr));
        check_value("sreg", 128'(1'b1), 128'(sreg_req_rdy));
        @(negedge clk);
        sreg_rsp = 32'h1234;
        sreg_rsp_enable = 1'b1;
        @(negedge clk);
        sreg_rsp_enable = 1'b0;
        take_write("sreg", addr, data);
        check_value("sreg", 128'(BASE + 32'd1), 128'(addr));
        check_value("sreg", {1'b1, 95'd0, 32'h1234}, data);
    endtask

    task automatic test_debug();
        logic [31:0] addr;
        logic [127:0] data;
        dbg.from_host = 32'h1111_0001;
        dbg.to_host = 32'h2222_0002;
        dbg.tester = 32'h3333_0003;
        csr_write(CSR_TRIGGER_DEBUG, 32'd2);
        take_write("debug", addr, data);
        check_value("debug", 128'(BASE + 32'd2), 128'(addr));
        // Index 2 picks the to-host word and the index sits right above it
        check_value("debug", {88'd0, 8'd2, 32'h2222_0002}, data);
    endtask

    task automatic test_progress();
        logic [31:0] addr;
        logic [127:0] data;
        @(negedge clk);
        fifo_local.oldest_read_idx = 6'd3;
        // Bit 3 is still clear, so the host hears nothing
        repeat (QUIET_CYCLES) @(negedge clk);
        check_value("progress", 128'd0, 128'(wr_addr_q.size()));
        fifo_local.oldest_read_idx = 6'd8;
        fifo_local.next_write_idx = 6'd2;
        take_write("progress", addr, data);
        check_value("progress", 128'(BASE + 32'd3), 128'(addr));
        check_value("progress", {64'd0, 32'd2, 32'd8}, data);
    endtask

    task automatic test_restart();
        logic [31:0] addr;
        logic [127:0] data;
        csr_write(CSR_ENABLE_TEST, 32'd0);
        take_write("restart", addr, data);
        check_value("restart", 128'(BASE), 128'(addr));
        check_value("restart", id_line(), data);
    endtask

    // ==========================================================
    // Main sequence and watchdog
    // ==========================================================

    initial
    begin
        errors = 0;
        checks = 0;
        resetb = 1'b0;
        csr_wr_valid = 1'b0;
        csr_wr_op = CSR_DSM_BASE;
        csr_wr_data = '0;
        fifo_local = '0;
        dbg = '0;
        sreg_rsp = '0;
        sreg_rsp_enable = 1'b0;
        poll_line = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        resetb = 1'b1;
        test_id_line();
        test_poll();
        test_sreg();
        test_debug();
        test_progress();
        test_restart();
        repeat (2) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/qa_status_top.sv ====
`default_nettype none

`include "qa_macros.svh"

module qa_status_top
(
    input  wire logic                               clk,
    input  wire logic                               resetb,
    input  wire logic                               csr_wr_valid,
    input  wire qa_status_pkg::csr_op_t             csr_wr_op,
    input  wire logic [31:0]                        csr_wr_data,
    output logic                                    mem_req,
    output qa_mem_pkg::mem_req_t                    mem_req_data,
    input  wire logic                               mem_ack,
    input  wire qa_mem_pkg::mem_rsp_t               mem_rsp,
    input  wire qa_status_pkg::fifo_local_ptrs_t    fifo_local,
    output qa_status_pkg::fifo_host_ptrs_t          fifo_host,
    input  wire qa_status_pkg::dbg_words_t          dbg,
    output logic [7:0]                              sreg_req_addr,
    output logic                                    sreg_req_rdy,
    input  wire logic [31:0]                        sreg_rsp,
    input  wire logic                               sreg_rsp_enable
);

    import qa_mem_pkg::*;
    import qa_status_pkg::*;

    csr_state_t csr;

    // Manager to memory port
    logic rd_req;
    logic wr_req;
    mem_req_t wr_line;
    logic rd_grant;
    logic wr_grant;
    logic rd_rsp_valid;
    mem_rsp_t rd_rsp;

    qa_csr_capture i_csr_capture
    (
        .clk            (clk),
        .resetb         (resetb),
        .csr_wr_valid   (csr_wr_valid),
        .csr_wr_op      (csr_wr_op),
        .csr_wr_data    (csr_wr_data),
        .csr            (csr)
    );

    qa_status_manager i_status_manager
    (
        .clk                (clk),
        .resetb             (resetb),
        .csr                (csr),
        .rd_grant           (rd_grant),
        .wr_grant           (wr_grant),
        .rd_rsp_valid       (rd_rsp_valid),
        .rd_rsp             (rd_rsp),
        .fifo_local         (fifo_local),
        .dbg                (dbg),
        .sreg_rsp           (sreg_rsp),
        .sreg_rsp_enable    (sreg_rsp_enable),
        .rd_req             (rd_req),
        .wr_req             (wr_req),
        .wr_line            (wr_line),
        .fifo_host          (fifo_host),
        .sreg_req_addr      (sreg_req_addr),
        .sreg_req_rdy       (sreg_req_rdy)
    );

    qa_mem_port i_mem_port
    (
        .clk            (clk),
        .resetb         (resetb),
        .rd_req         (rd_req),
        .wr_req         (wr_req),
        .wr_line        (wr_line),
        .mem_ack        (mem_ack),
        .mem_rsp        (mem_rsp),
        .rd_grant       (rd_grant),
        .wr_grant       (wr_grant),
        .rd_rsp_valid   (rd_rsp_valid),
        .rd_rsp         (rd_rsp),
        .mem_req        (mem_req),
        .mem_req_data   (mem_req_data)
    );

endmodule

`default_nettype wire

// ==== design/qa_mem_port.sv ====
`default_nettype none

`include "qa_macros.svh"

module qa_mem_port
(
    input  wire logic                   clk,
    input  wire logic                   resetb,
    input  wire logic                   rd_req,
    input  wire logic                   wr_req,
    input  wire qa_mem_pkg::mem_req_t   wr_line,
    input  wire logic                   mem_ack,
    input  wire qa_mem_pkg::mem_rsp_t   mem_rsp,
    output logic                        rd_grant,
    output logic                        wr_grant,
    output logic                        rd_rsp_valid,
    output qa_mem_pkg::mem_rsp_t        rd_rsp,
    output logic                        mem_req,
    output qa_mem_pkg::mem_req_t        mem_req_data
);

    import qa_mem_pkg::*;

    typedef enum logic [1:0]
    {
        P_IDLE,
        P_REQ,
        P_REL,
        P_ACK_LOW
    } port_state_t;

    port_state_t state;
    mem_req_t req_q;
    mem_rsp_t rsp_q;

    // Four-phase master, one transaction at a time
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state <= P_IDLE;
            rd_grant <= 1'b0;
            wr_grant <= 1'b0;
            rd_rsp_valid <= 1'b0;
        end
        else
        begin
            rd_grant <= 1'b0;
            wr_grant <= 1'b0;
            rd_rsp_valid <= 1'b0;
            case (state)
                P_IDLE:
                    if (wr_req || rd_req)
                        state <= P_REQ;
                P_REQ:
                    // Ack seen, so the grant and any read data go out now
                    if (mem_ack)
                    begin
                        rd_grant <= (req_q.op == MEM_RD_LINE);
                        wr_grant <= (req_q.op == MEM_WR_LINE);
                        rd_rsp_valid <= (req_q.op == MEM_RD_LINE);
                        state <= P_REL;
                    end
                P_REL:
                    state <= P_ACK_LOW;
                default:
                    if (!mem_ack)
                        state <= P_IDLE;
            endcase
        end
    end

    // A pending write wins, the line then holds the write contents
    always_ff @(posedge clk)
    begin
        if ((state == P_IDLE) && (wr_req || rd_req))
        begin
            req_q.op <= wr_req ? MEM_WR_LINE : MEM_RD_LINE;
            req_q.addr <= wr_line.addr;
            req_q.data <= wr_line.data;
        end
        if ((state == P_REQ) && mem_ack && (req_q.op == MEM_RD_LINE))
        begin
            rsp_q <= mem_rsp;
        end
    end

    assign mem_req = (state == P_REQ);
    assign mem_req_data = req_q;
    assign rd_rsp = rsp_q;

endmodule

`default_nettype wire

// ==== design/qa_status_manager.sv ====
`default_nettype none

`include "qa_macros.svh"

module qa_status_manager
(
    input  wire logic                               clk,
    input  wire logic                               resetb,
    input  wire qa_status_pkg::csr_state_t          csr,
    input  wire logic                               rd_grant,
    input  wire logic                               wr_grant,
    input  wire logic                               rd_rsp_valid,
    input  wire qa_mem_pkg::mem_rsp_t               rd_rsp,
    input  wire qa_status_pkg::fifo_local_ptrs_t    fifo_local,
    input  wire qa_status_pkg::dbg_words_t          dbg,
    input  wire logic [31:0]                        sreg_rsp,
    input  wire logic                               sreg_rsp_enable,
    output logic                                    rd_req,
    output logic                                    wr_req,
    output qa_mem_pkg::mem_req_t                    wr_line,
    output qa_status_pkg::fifo_host_ptrs_t          fifo_host,
    output logic [7:0]                              sreg_req_addr,
    output logic                                    sreg_req_rdy
);

    import qa_mem_pkg::*;
    import qa_status_pkg::*;

    // ==========================================================
    // Poll reader
    // ==========================================================

    rd_state_t state_rd;
    logic rsp_seen;

    // The response arrives together with the grant, so it is looked at
    // one cycle later once the reader sits in RD_WAIT
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            state_rd <= RD_POLL;
            rsp_seen <= 1'b0;
            fifo_host <= '0;
        end
        else
        begin
            rsp_seen <= rd_rsp_valid;
            if ((state_rd == RD_POLL) && rd_grant)
            begin
                state_rd <= RD_WAIT;
            end
            else if ((state_rd == RD_WAIT) && rsp_seen)
            begin
                state_rd <= RD_POLL;
                // Word 0 is the host's newest line, word 1 its oldest unread
                fifo_host.newest_read_idx <= rd_rsp.data[`QA_FROM_HOST_IDX_BITS-1:0];
                fifo_host.oldest_write_idx <= rd_rsp.data[32 +: `QA_TO_HOST_IDX_BITS];
            end
        end
    end

    // No point polling before the host has told us where DSM lives
    assign rd_req = (state_rd == RD_POLL) && csr.dsm_base_valid;

    // ==========================================================
    // Status writer
    // ==========================================================

    wr_state_t state_wr;

    // Only one line in flight, a grant always brings the writer home
    always_ff @(posedge clk)
    begin
        if (!resetb)
            state_wr <= WR_INIT;
        else if (wr_grant)
            state_wr <= WR_IDLE;
        else if (csr.enable_test)
            state_wr <= WR_INIT;
        else if (csr.debug_idx != 8'd0)
            state_wr <= WR_DEBUG;
        else if (sreg_rsp_enable)
            state_wr <= WR_STATUS;
    end

    // Progress tracking.  The local pointers are frozen while a write of
    // them is pending so the line contents stay stable until the grant
    fifo_local_ptrs_t local_q;
    fifo_local_ptrs_t last_written;
    logic need_update;
    logic prog_granted;

    assign prog_granted = need_update && (state_wr == WR_IDLE) && wr_grant;

    always_ff @(posedge clk)
    begin
        if (!need_update)
        begin
            local_q <= fifo_local;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            last_written <= '0;
            need_update <= 1'b0;
        end
        else if (need_update)
        begin
            if (prog_granted)
            begin
                need_update <= 1'b0;
                last_written <= local_q;
            end
        end
        else
        begin
            // Only a toggle of the monitored bit counts on the from-host side
            need_update <=
                (local_q.oldest_read_idx[`QA_MONITOR_BIT] !=
                 last_written.oldest_read_idx[`QA_MONITOR_BIT]) ||
                (local_q.next_write_idx != last_written.next_write_idx);
        end
    end

    // Debug index and its word are captured when the trigger fires
    logic [7:0]  dbg_idx_q;
    logic [31:0] dbg_word_q;
    logic [31:0] dbg_sel;

    always_comb
    begin
        case (csr.debug_idx)
            8'd1: dbg_sel = dbg.from_host;
            8'd2: dbg_sel = dbg.to_host;
            8'd3: dbg_sel = dbg.tester;
            default: dbg_sel = dbg.from_host;
        endcase
    end

    // Status register client response, held for the STATUS write
    logic [31:0] sreg_q;

    always_ff @(posedge clk)
    begin
        if (csr.debug_idx != 8'd0)
        begin
            dbg_idx_q <= csr.debug_idx;
            dbg_word_q <= dbg_sel;
        end
        if (sreg_rsp_enable)
        begin
            sreg_q <= sreg_rsp;
        end
    end

    assign sreg_req_addr = csr.sreg_addr;
    assign sreg_req_rdy = csr.sreg_enable;

    // ==========================================================
    // Line formatting
    // ==========================================================

    logic [31:0] offset;
    logic [`QA_LINE_BITS-1:0] data;

    always_comb
    begin
        case (state_wr)
            WR_DEBUG:
            begin
                offset = 32'(`QA_DSM_OFF_DEBUG_RSP);
                data = `QA_LINE_BITS'({dbg_idx_q, dbg_word_q});
            end
            WR_STATUS:
            begin
                offset = 32'(`QA_DSM_OFF_SREG_RSP);
                data = `QA_LINE_BITS'(sreg_q);
                // Top bit tells the host the response has landed
                data[`QA_LINE_BITS-1] = 1'b1;
            end
            WR_IDLE:
            begin
                offset = 32'(`QA_DSM_OFF_FIFO_STATE);
                data = `QA_LINE_BITS'({32'(local_q.next_write_idx),
                                       32'(local_q.oldest_read_idx)});
            end
            default:
            begin
                // ID line with ring depths minus one in words 2 and 3
                offset = 32'(`QA_DSM_OFF_AFU_ID);
                data = {32'((1 << `QA_TO_HOST_IDX_BITS) - 1),
                        32'((1 << `QA_FROM_HOST_IDX_BITS) - 1),
                        `QA_AFU_ID1, `QA_AFU_ID0};
            end
        endcase

        if (state_wr != WR_IDLE)
            wr_req = csr.dsm_base_valid;
        else
            wr_req = need_update;

        // Without a pending write the line carries the poll read instead
        if (wr_req)
        begin
            wr_line.op = MEM_WR_LINE;
            wr_line.addr = csr.dsm_base + offset;
            wr_line.data = data;
        end
        else
        begin
            wr_line.op = MEM_RD_LINE;
            wr_line.addr = csr.dsm_base + 32'(`QA_DSM_OFF_POLL_STATE);
            wr_line.data = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/qa_csr_capture.sv ====
`default_nettype none

`include "qa_macros.svh"

module qa_csr_capture
(
    input  wire logic                       clk,
    input  wire logic                       resetb,
    input  wire logic                       csr_wr_valid,
    input  wire qa_status_pkg::csr_op_t     csr_wr_op,
    input  wire logic [31:0]                csr_wr_data,
    output qa_status_pkg::csr_state_t       csr
);

    import qa_status_pkg::*;

    // Held payload
    logic [31:0]    dsm_base;
    logic [7:0]     sreg_addr;

    // Control state
    logic           dsm_base_valid;
    logic           enable_test;
    logic [7:0]     debug_idx;
    logic           sreg_enable;

    // Triggers last exactly one cycle, the rest stays until rewritten
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            dsm_base_valid <= 1'b0;
            enable_test <= 1'b0;
            debug_idx <= 8'd0;
            sreg_enable <= 1'b0;
        end
        else
        begin
            enable_test <= csr_wr_valid && (csr_wr_op == CSR_ENABLE_TEST);
            debug_idx <= (csr_wr_valid && (csr_wr_op == CSR_TRIGGER_DEBUG)) ?
                         csr_wr_data[7:0] : 8'd0;

            // Once the host names a DSM base the writer may start
            if (csr_wr_valid && (csr_wr_op == CSR_DSM_BASE))
            begin
                dsm_base_valid <= 1'b1;
            end

            // A status register request stays open toward the client
            if (csr_wr_valid && (csr_wr_op == CSR_SREG_REQ))
            begin
                sreg_enable <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (csr_wr_valid && (csr_wr_op == CSR_DSM_BASE))
        begin
            dsm_base <= csr_wr_data;
        end

        if (csr_wr_valid && (csr_wr_op == CSR_SREG_REQ))
        begin
            sreg_addr <= csr_wr_data[7:0];
        end
    end

    assign csr = '{dsm_base:       dsm_base,
                   dsm_base_valid: dsm_base_valid,
                   enable_test:    enable_test,
                   debug_idx:      debug_idx,
                   sreg_addr:      sreg_addr,
                   sreg_enable:    sreg_enable};

endmodule

`default_nettype wire

// ==== design/qa_status_pkg.sv ====
`default_nettype none

`include "qa_macros.svh"

// ==========================================================
// Status side types
// ==========================================================

package qa_status_pkg;

    // CSR write opcodes from the host
    typedef enum logic [1:0]
    {
        CSR_DSM_BASE,
        CSR_ENABLE_TEST,
        CSR_TRIGGER_DEBUG,
        CSR_SREG_REQ
    } csr_op_t;

    // Held CSR fields plus the two single-cycle triggers
    typedef struct packed
    {
        logic [31:0]    dsm_base;
        logic           dsm_base_valid;
        logic           enable_test;
        logic [7:0]     debug_idx;
        logic [7:0]     sreg_addr;
        logic           sreg_enable;
    } csr_state_t;

    // Pointers owned by the local FIFOs
    typedef struct packed
    {
        logic [`QA_FROM_HOST_IDX_BITS-1:0]  oldest_read_idx;
        logic [`QA_TO_HOST_IDX_BITS-1:0]    next_write_idx;
    } fifo_local_ptrs_t;

    // Pointers learned by polling the host
    typedef struct packed
    {
        logic [`QA_FROM_HOST_IDX_BITS-1:0]  newest_read_idx;
        logic [`QA_TO_HOST_IDX_BITS-1:0]    oldest_write_idx;
    } fifo_host_ptrs_t;

    // Debug words offered by the neighbouring blocks
    typedef struct packed
    {
        logic [31:0]    from_host;
        logic [31:0]    to_host;
        logic [31:0]    tester;
    } dbg_words_t;

    typedef enum logic
    {
        RD_POLL,
        RD_WAIT
    } rd_state_t;

    typedef enum logic [1:0]
    {
        WR_INIT,
        WR_IDLE,
        WR_DEBUG,
        WR_STATUS
    } wr_state_t;

endpackage

`default_nettype wire

// ==== design/qa_mem_pkg.sv ====
`default_nettype none

`include "qa_macros.svh"

// ==========================================================
// Memory side types
// ==========================================================

package qa_mem_pkg;

    // Line-sized read or write toward host memory
    typedef enum logic
    {
        MEM_RD_LINE,
        MEM_WR_LINE
    } mem_op_t;

    // One request as presented on the four-phase bus
    typedef struct packed
    {
        mem_op_t                        op;
        logic [`QA_DSM_ADDR_BITS-1:0]   addr;
        logic [`QA_LINE_BITS-1:0]       data;
    } mem_req_t;

    // Read data returned by the host while ack is high
    typedef struct packed
    {
        logic [`QA_LINE_BITS-1:0]       data;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== design/qa_macros.svh ====
`ifndef QA_MACROS_SVH
`define QA_MACROS_SVH

// One DSM line is four 32-bit words
`define QA_LINE_BITS 128
`define QA_DSM_ADDR_BITS 32

// Ring index widths of the two host FIFOs
`define QA_FROM_HOST_IDX_BITS 6
`define QA_TO_HOST_IDX_BITS 6

// Index bit whose toggle is worth a progress write to the host
`define QA_MONITOR_BIT (`QA_FROM_HOST_IDX_BITS - 3)

// Line offsets from the DSM base, these must agree with the host software
`define QA_DSM_OFF_AFU_ID 0
`define QA_DSM_OFF_SREG_RSP 1
`define QA_DSM_OFF_DEBUG_RSP 2
`define QA_DSM_OFF_FIFO_STATE 3
`define QA_DSM_OFF_POLL_STATE 4

// Signature words at the head of the ID line
`define QA_AFU_ID0 32'haced0000
`define QA_AFU_ID1 32'haced0001

`endif
